// File: bpMode.f
+incdir+include
verilog/bpPkg.sv
verilog/bpPredIf.sv
verilog/sliceContext.sv
verilog/blockPipeTimer.sv
verilog/leftHistory.sv
verilog/bpvSelector.sv
verilog/dequantRecon.sv
verilog/bpMode.sv
testbench/bpMode_chk.sv
testbench/bpMode_mon.sv
testbench/bpMode_tb.sv

// File: include/bp_defs.svh
// Widths and counts for the 4:4:4 block-prediction path only; chroma subsampling is not supported
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Sample widths
`define BP_PIX_W        14
`define BP_QUANT_W      17
`define BP_QP_W         7

// Block geometry, 4:4:4 so every component is 2x8
`define BP_NUM_COMP     3
`define BP_ROWS         2
`define BP_COLS         8
`define BP_NUM_SUB      4

// Candidate vectors and search ranges
`define BP_NUM_BPV      64
`define BP_ABOVE_LEN    33
`define BP_RANGE_C_LEN  33
`define BP_LEFT_BLKS    4

`endif

// File: run.sh
#!/bin/sh
# Build and run the bpMode testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
  -f bpMode.f --top-module bpMode_tb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "Simulation did not reach its end"
  exit 1
fi
exit 0

// File: testbench/bpMode_chk.sv
// Bound to bpMode; assumes flush drops blocks in flight and that reset is asynchronous
`timescale 1ns/1ps
`include "bp_defs.svh"

module bpMode_chk (
  input logic                                                          clk,
  input logic                                                          rst_n,
  input logic                                                          flush,
  input logic                                                          parsed,
  input logic                                                          reconValid,
  input bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  reconBlk,
  input bpPkg::sliceState_e                                            state
);

  // A block not hit by flush comes out three cycles later
  latencyA: assert property (@(posedge clk) disable iff (!rst_n)
    (parsed && !flush) ##1 !flush ##1 !flush |=> reconValid)
    else $error("reconValid missing three cycles after parsed");

  knownA: assert property (@(posedge clk) disable iff (!rst_n)
    reconValid |-> !$isunknown(reconBlk))
    else $error("reconBlk unknown while reconValid");

  stateA: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(state) && (state <= bpPkg::RUN))
    else $error("slice state out of range");

endmodule

bind bpMode bpMode_chk i_chk (.*);

// File: testbench/bpMode_mon.sv
// Reference model at the bpMode ports; samples on rising edges, inputs must be driven on falling edges
`timescale 1ns/1ps
`include "bp_defs.svh"

module bpMode_mon (
  input logic                                                          clk,
  input logic                                                          rst_n,
  input logic                                                          flush,
  input logic [1:0]                                                    csc,
  input logic [12:0]                                                   midPoint,
  input logic [12:0]                                                   maxPoint,
  input logic [`BP_NUM_COMP-1:0][`BP_PIX_W-1:0]                        minPoint,
  input logic                                                          fbls,
  input logic                                                          qpValid,
  input logic signed [7:0]                                             masterQp,
  input logic signed [6:0]                                             minQp,
  input logic [8:0]                                                    maxQp,
  input logic                                                          sos,
  input logic                                                          leftValid,
  input bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  leftBlk,
  input bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ABOVE_LEN-1:0]           aboveRow,
  input logic                                                          parsed,
  input bpPkg::blockMode_e                                             blockMode,
  input logic [`BP_NUM_SUB-1:0]                                        bpvTable,
  input bpPkg::sel_t [`BP_NUM_SUB-1:0]                                 sel2x2,
  input bpPkg::sel_t [`BP_NUM_SUB-1:0][`BP_ROWS-1:0]                   sel2x1,
  input bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  quant,
  input bpPkg::qp_t [`BP_NUM_COMP-1:0]                                 qp,
  input logic signed [7:0]                                             masterQpForBp,
  input logic                                                          reconValid,
  input bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  reconBlk
);

  typedef bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] blk_t;

  int errorCount = 0;
  int checkCount = 0;

  int invScale [8] = '{128, 140, 152, 164, 180, 196, 216, 236};

  bpPkg::sliceState_e mState;
  logic mFirst;
  logic [2:0] live;                          // Model stage valids
  bpPkg::pixel_t hist [4][3][2][8];          // 0 oldest
  bpPkg::pixel_t edgeCol [3][2];
  blk_t s1Pred, s2Pred, expOut;
  bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] s1Quant;
  bpPkg::qp_t [`BP_NUM_COMP-1:0] s1Qp;
  bpPkg::blockMode_e s1Mode, s2Mode;
  longint s2Res [3][2][8];

  function automatic bpPkg::pixel_t meanOf(input int c);
    return (csc == 2'd1 && c > 0) ? '0 : bpPkg::pixel_t'(midPoint);
  endfunction

  // Flat C index, row 0 holds 0..32 and row 1 holds 33..65
  function automatic bpPkg::pixel_t rangeCAt(input int c, input int i);
    int row;
    int idx;
    int k;
    row = i / 33;
    idx = i % 33;
    if (idx == 0) begin
      return (mState == bpPkg::RUN) ? edgeCol[c][row] : meanOf(c);
    end
    k = (idx - 1) / 8;
    if (int'(mState) >= int'(bpPkg::BLK4) - k) begin
      return hist[k][c][row][(idx - 1) % 8];
    end
    return meanOf(c);
  endfunction

  function automatic bpPkg::pixel_t vecPix(input int c, input int v, input int p, input int j);
    if (v < 7) begin
      if (p == 0) begin
        return mFirst ? meanOf(c) : aboveRow[c][32 - (v + j)];
      end
      return rangeCAt(c, 25 + v + j);
    end else if (v == 7) begin
      if (p == 1) return rangeCAt(c, 32);
      return (j == 0) ? (mFirst ? meanOf(c) : aboveRow[c][25]) : aboveRow[c][24];
    end else if (v < 32) begin
      return aboveRow[c][24 - (v - 8 + j)];
    end
    return (p == 0) ? rangeCAt(c, v - 32 + j) : rangeCAt(c, v + 1 + j);
  endfunction

  function automatic longint dequantRef(input bpPkg::quant_t q, input bpPkg::qp_t qv);
    longint scale;
    longint mag;
    int sh;
    scale = invScale[qv % 8];
    sh = 9 - qv / 8;
    if (sh > 0) begin
      mag = (((q < 0) ? -longint'(q) : longint'(q)) * scale + (64'sd1 << (sh - 1))) >>> sh;
      return (q < 0) ? -mag : mag;
    end
    return (longint'(q) * scale) <<< (-sh);
  endfunction

  function automatic bpPkg::pixel_t clipRef(input bpPkg::pixel_t p, input longint res, input int c);
    longint sum;
    longint lo;
    sum = longint'(p) + res;
    lo = longint'($signed(minPoint[c]));
    if (sum < lo) return bpPkg::pixel_t'(lo);
    if (sum > longint'(maxPoint)) return bpPkg::pixel_t'(maxPoint);
    return bpPkg::pixel_t'(sum);
  endfunction

  always @(posedge clk or negedge rst_n) begin : modelStep
    int qs;
    int s;
    if (!rst_n) begin
      mState <= bpPkg::IDLE;
      mFirst <= 1'b1;
      live <= '0;
    end else begin
      // ************************************************************************
      // Compare outputs from the cycle just ended
      // ************************************************************************
      qs = int'(masterQp) + (mFirst ? 4 : 2);
      if (qs < int'(minQp)) qs = int'(minQp);
      else if (qs > int'(maxQp)) qs = int'(maxQp);
      checkCount++;
      if (masterQpForBp !== 8'(qs)) begin
        errorCount++;
        $display("CHECK FAILED masterQpForBp got %h exp %h", masterQpForBp, 8'(qs));
      end
      checkCount++;
      if (reconValid !== live[2]) begin
        errorCount++;
        $display("CHECK FAILED reconValid got %h exp %h", reconValid, live[2]);
      end
      if (live[2]) begin
        for (int c = 0; c < 3; c++)
          for (int r = 0; r < 2; r++)
            for (int x = 0; x < 8; x++) begin
              checkCount++;
              if (reconBlk[c][r][x] !== expOut[c][r][x]) begin
                errorCount++;
                $display("CHECK FAILED reconBlk[%0d][%0d][%0d] got %h exp %h",
                         c, r, x, reconBlk[c][r][x], expOut[c][r][x]);
              end
            end
      end

      // Advance the pipeline, oldest stage first
      if (live[1]) begin
        for (int c = 0; c < 3; c++)
          for (int r = 0; r < 2; r++)
            for (int x = 0; x < 8; x++) begin
              if (s2Mode == bpPkg::MODE_BP) expOut[c][r][x] = clipRef(s2Pred[c][r][x], s2Res[c][r][x], c);
              else if (s2Mode == bpPkg::MODE_BP_SKIP) expOut[c][r][x] = s2Pred[c][r][x];
            end
      end
      if (live[0]) begin
        s2Pred = s1Pred;
        s2Mode = s1Mode;
        for (int c = 0; c < 3; c++)
          for (int r = 0; r < 2; r++)
            for (int x = 0; x < 8; x++) s2Res[c][r][x] = dequantRef(s1Quant[c][r][x], s1Qp[c]);
      end
      if (parsed) begin
        for (int c = 0; c < 3; c++)
          for (int r = 0; r < 2; r++)
            for (int x = 0; x < 8; x++) begin
              s = bpvTable[x / 2] ? int'(sel2x2[x / 2]) : int'(sel2x1[x / 2][r]);
              s1Pred[c][r][x] = vecPix(c, s, r, x % 2);
            end
        s1Quant = quant;
        s1Qp = qp;
        s1Mode = blockMode;
      end
      live <= flush ? 3'b000 : {live[1:0], parsed};

      // Slice state and left history
      if (leftValid) begin
        for (int c = 0; c < 3; c++)
          for (int r = 0; r < 2; r++) begin
            edgeCol[c][r] = hist[0][c][r][7];
            for (int k = 0; k < 3; k++) hist[k][c][r] = hist[k + 1][c][r];
            for (int x = 0; x < 8; x++) hist[3][c][r][x] = leftBlk[c][r][x];
          end
      end
      if (flush) mState <= bpPkg::IDLE;
      else if (mState == bpPkg::IDLE || mState == bpPkg::RUN) begin
        if (sos) mState <= bpPkg::SOS;
      end else if (leftValid) mState <= bpPkg::sliceState_e'(mState + 3'd1);
      if (flush) mFirst <= 1'b1;
      else if (qpValid) mFirst <= fbls;
    end
  end

endmodule

// File: testbench/bpMode_tb.sv
// Random BP stream from a fixed xorshift seed; never raises parsed and leftValid together
`timescale 1ns/1ps
`include "bp_defs.svh"

module bpMode_tb;

  localparam int NumBlocks = 2000;
  localparam int CycleLimit = NumBlocks * 6 + 16 + 100;

  logic clk, rst_n, flush, fbls, qpValid, sos, leftValid, parsed;
  logic [1:0] csc;
  logic [12:0] midPoint, maxPoint;
  logic [`BP_NUM_COMP-1:0][`BP_PIX_W-1:0] minPoint;
  logic signed [7:0] masterQp;
  logic signed [6:0] minQp;
  logic [8:0] maxQp;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] leftBlk;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ABOVE_LEN-1:0] aboveRow;
  bpPkg::blockMode_e blockMode;
  logic [`BP_NUM_SUB-1:0] bpvTable;
  bpPkg::sel_t [`BP_NUM_SUB-1:0] sel2x2;
  bpPkg::sel_t [`BP_NUM_SUB-1:0][`BP_ROWS-1:0] sel2x1;
  bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] quant;
  bpPkg::qp_t [`BP_NUM_COMP-1:0] qp;
  logic signed [7:0] masterQpForBp;
  logic reconValid;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] reconBlk;

  logic [31:0] rngState = 32'hf7c9;
  int blocksSent = 0;
  int cycles = 0;

  bpMode i_dut (.*);
  bpMode_mon i_mon (.*);

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic loadBlock(input bit forceBp);
    logic [31:0] r;
    r = nextRand();
    case (r[2:0])
      3'd0, 3'd1, 3'd2, 3'd3: blockMode = bpPkg::MODE_BP;
      3'd4, 3'd5: blockMode = bpPkg::MODE_BP_SKIP;
      3'd6: blockMode = bpPkg::MODE_XFORM;
      default: blockMode = bpPkg::MODE_MPP;
    endcase
    if (forceBp) blockMode = bpPkg::MODE_BP;
    bpvTable = r[6:3];
    for (int b = 0; b < 4; b++) begin
      sel2x2[b] = bpPkg::sel_t'(nextRand());
      sel2x1[b][0] = bpPkg::sel_t'(nextRand());
      sel2x1[b][1] = bpPkg::sel_t'(nextRand());
    end
    for (int c = 0; c < 3; c++) begin
      qp[c] = bpPkg::qp_t'(nextRand());
      for (int k = 0; k < `BP_ABOVE_LEN; k++) aboveRow[c][k] = bpPkg::pixel_t'(nextRand());
      for (int i = 0; i < 16; i++) begin
        r = nextRand();
        // Mostly small residuals so results land inside the clip range
        quant[c][i / 8][i % 8] = r[31] ? bpPkg::quant_t'(r[16:0])
                                       : bpPkg::quant_t'($signed(r[9:0]));
      end
    end
  endtask

  initial begin : stimulus
    logic [31:0] r;
    rst_n = 1'b0;
    {flush, fbls, qpValid, sos, leftValid, parsed} = '0;
    csc = 2'd0;
    midPoint = 13'd4096;
    maxPoint = 13'd8191;
    minPoint = '0;
    masterQp = 8'sd20;
    minQp = 7'sd0;
    maxQp = 9'd72;
    leftBlk = '0;
    loadBlock(1'b1); // First output must be written
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    parsed = 1'b1;
    blocksSent++;
    @(negedge clk);
    parsed = 1'b0;
    repeat (3) @(negedge clk); // First block reaches reconBlk before any flush
    while (blocksSent < NumBlocks) begin
      @(negedge clk);
      {flush, qpValid, sos, leftValid, parsed} = '0;
      r = nextRand();
      if (r[7:0] < 8'd3) begin
        sos = 1'b1;
      end else if (r[7:0] < 8'd40) begin
        leftValid = 1'b1;
        for (int i = 0; i < 48; i++) begin
          leftBlk[i / 16][(i / 8) % 2][i % 8] = bpPkg::pixel_t'(nextRand());
        end
      end else if (r[7:0] < 8'd50) begin
        qpValid = 1'b1;
        fbls = r[8];
        masterQp = $signed(r[16:9]);
        minQp = $signed(r[23:17]);
        maxQp = r[31:23];
      end else if (r[7:0] < 8'd52) begin
        flush = 1'b1;
      end else if (r[7:0] < 8'd60) begin
        csc = r[9:8];
        midPoint = r[22:10];
        maxPoint = 13'd4096 + 13'(r[31:20]);
        for (int c = 0; c < 3; c++) minPoint[c] = 14'($signed(nextRand() & 32'h3f) - 32);
      end else if (r[7:0] < 8'd200) begin
        loadBlock(1'b0);
        parsed = 1'b1;
        blocksSent++;
      end
    end
    @(negedge clk);
    {flush, qpValid, sos, leftValid, parsed} = '0;
    repeat (10) @(posedge clk);
    $display("Checks: %0d  Errors: %0d  Blocks: %0d", i_mon.checkCount, i_mon.errorCount,
             blocksSent);
    if (i_mon.errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Hard stop if the stream never ends
  initial begin : watchdog
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d blocks sent", cycles, blocksSent);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog/blockPipeTimer.sv
// Fixed three-cycle block latency with no stall; flush drops every block in flight
`timescale 1ns/1ps

module blockPipeTimer (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  input  logic parsed,
  output logic stage1Valid,
  output logic stage2Valid,
  output logic reconValid
);

  logic [2:0] live; // One bit per stage register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live <= '0;
    end else if (flush) begin
      live <= '0;
    end else begin
      live <= {live[1:0], parsed};
    end
  end

  assign stage1Valid = live[0]; // Selector output register
  assign stage2Valid = live[1]; // Dequant register
  assign reconValid  = live[2]; // Output block register

endmodule

// File: verilog/bpMode.sv
// BP reconstruction top for 4:4:4; parsed and leftValid are never expected in the same cycle
`timescale 1ns/1ps
`include "bp_defs.svh"

module bpMode (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic                                                          flush,
  input  logic [1:0]                                                    csc,
  input  logic [12:0]                                                   midPoint,
  input  logic [12:0]                                                   maxPoint,
  input  logic [`BP_NUM_COMP-1:0][`BP_PIX_W-1:0]                        minPoint,
  input  logic                                                          fbls,
  input  logic                                                          qpValid,
  input  logic signed [7:0]                                             masterQp,
  input  logic signed [6:0]                                             minQp,
  input  logic [8:0]                                                    maxQp,
  input  logic                                                          sos,
  input  logic                                                          leftValid,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  leftBlk,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ABOVE_LEN-1:0]           aboveRow,
  input  logic                                                          parsed,
  input  bpPkg::blockMode_e                                             blockMode,
  input  logic [`BP_NUM_SUB-1:0]                                        bpvTable,
  input  bpPkg::sel_t [`BP_NUM_SUB-1:0]                                 sel2x2,
  input  bpPkg::sel_t [`BP_NUM_SUB-1:0][`BP_ROWS-1:0]                   sel2x1,
  input  bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  quant,
  input  bpPkg::qp_t [`BP_NUM_COMP-1:0]                                 qp,
  output logic signed [7:0]                                             masterQpForBp,
  output logic                                                          reconValid,
  output bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  reconBlk
);

  bpPkg::sliceState_e state;
  logic firstLine;
  logic stage1Valid;
  logic stage2Valid;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0] meanValue;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_RANGE_C_LEN-1:0] rangeC;

  bpPredIf predBus ();

  sliceContext i_sliceContext (
    .clk, .rst_n, .flush, .sos, .leftValid, .fbls, .qpValid, .csc, .midPoint,
    .masterQp, .minQp, .maxQp, .masterQpForBp, .state, .firstLine, .meanValue
  );

  blockPipeTimer i_blockPipeTimer (
    .clk, .rst_n, .flush, .parsed, .stage1Valid, .stage2Valid, .reconValid
  );

  leftHistory i_leftHistory (
    .clk, .leftValid, .leftBlk, .state, .meanValue, .rangeC
  );

  bpvSelector i_bpvSelector (
    .clk, .parsed, .firstLine, .meanValue, .aboveRow, .rangeC, .blockMode,
    .bpvTable, .sel2x2, .sel2x1, .quant, .qp, .predOut(predBus)
  );

  dequantRecon i_dequantRecon (
    .clk, .stage1Valid, .stage2Valid, .minPoint, .maxPoint,
    .predIn(predBus), .reconBlk
  );

endmodule

// File: verilog/bpPkg.sv
// Shared BP types; widths follow bp_defs.svh and must not be changed per instance
`include "bp_defs.svh"

package bpPkg;

  typedef logic [`BP_PIX_W-1:0] pixel_t;
  typedef logic signed [`BP_QUANT_W-1:0] quant_t;
  typedef logic [`BP_QP_W-1:0] qp_t;
  typedef logic [$clog2(`BP_NUM_BPV)-1:0] sel_t; // Vector index

  // Block coding modes, only BP and BP-skip are handled here
  typedef enum logic [2:0] {
    MODE_XFORM   = 3'd0,
    MODE_BP      = 3'd1,
    MODE_MPP     = 3'd2,
    MODE_MPPF    = 3'd3,
    MODE_BP_SKIP = 3'd4
  } blockMode_e;

  // Start-of-slice progress, counts left blocks seen
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    SOS  = 3'd1,
    BLK1 = 3'd2,
    BLK2 = 3'd3,
    BLK3 = 3'd4,
    BLK4 = 3'd5,
    RUN  = 3'd6
  } sliceState_e;

endpackage

// File: verilog/bpPredIf.sv
// Predicted block and residual context; contents only meaningful while stage1Valid is high
`timescale 1ns/1ps
`include "bp_defs.svh"

interface bpPredIf;

  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] pred;
  bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] quant;
  bpPkg::qp_t    [`BP_NUM_COMP-1:0]                             qp;
  bpPkg::blockMode_e                                            mode;

  modport src (output pred, quant, qp, mode);
  modport dst (input pred, quant, qp, mode);

endinterface

// File: verilog/bpvSelector.sv
// Builds all 64 candidates per component from current search ranges; 4:4:4 layout only
`timescale 1ns/1ps
`include "bp_defs.svh"

module bpvSelector (
  input  logic                                                          clk,
  input  logic                                                          parsed,
  input  logic                                                          firstLine,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0]                              meanValue,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ABOVE_LEN-1:0]           aboveRow,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_RANGE_C_LEN-1:0] rangeC,
  input  bpPkg::blockMode_e                                             blockMode,
  input  logic [`BP_NUM_SUB-1:0]                                        bpvTable,
  input  bpPkg::sel_t [`BP_NUM_SUB-1:0]                                 sel2x2,
  input  bpPkg::sel_t [`BP_NUM_SUB-1:0][`BP_ROWS-1:0]                   sel2x1,
  input  bpPkg::quant_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  quant,
  input  bpPkg::qp_t [`BP_NUM_COMP-1:0]                                 qp,
  bpPredIf.src                                                          predOut
);

  localparam int LenA = `BP_COLS;
  localparam int LenB = `BP_ABOVE_LEN - `BP_COLS;
  localparam int LenC = 2 * `BP_RANGE_C_LEN;

  bpPkg::pixel_t [`BP_NUM_COMP-1:0][LenA-1:0] rangeA;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][LenB-1:0] rangeB;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][LenC-1:0] cFlat;  // Row 0 then row 1
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_NUM_BPV-1:0][1:0][1:0] bpv; // [vec][pair][pix]
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] predNext;

  always_comb begin
    for (int c = 0; c < `BP_NUM_COMP; c++) begin
      for (int k = 0; k < LenA; k++) begin
        rangeA[c][k] = firstLine ? meanValue[c] : aboveRow[c][`BP_ABOVE_LEN-1-k];
      end
      for (int k = 0; k < LenB; k++) begin
        rangeB[c][k] = aboveRow[c][LenB-1-k];
      end
      for (int k = 0; k < LenC; k++) begin
        cFlat[c][k] = rangeC[c][k / `BP_RANGE_C_LEN][k % `BP_RANGE_C_LEN];
      end
    end
  end

  // ************************************************************************
  // Candidate vectors, C indices run across both rows
  // ************************************************************************
  always_comb begin
    for (int c = 0; c < `BP_NUM_COMP; c++) begin
      for (int v = 0; v < 7; v++) begin
        for (int j = 0; j < 2; j++) begin
          bpv[c][v][0][j] = rangeA[c][v+j];
          bpv[c][v][1][j] = cFlat[c][25+v+j];
        end
      end
      bpv[c][7][0][0] = rangeA[c][7]; // Straddles A and B
      bpv[c][7][0][1] = rangeB[c][0];
      bpv[c][7][1][0] = cFlat[c][32];
      bpv[c][7][1][1] = cFlat[c][32];
      for (int v = 8; v < 32; v++) begin
        for (int j = 0; j < 2; j++) begin
          bpv[c][v][0][j] = rangeB[c][v-8+j];
          bpv[c][v][1][j] = rangeB[c][v-8+j];
        end
      end
      for (int v = 32; v < `BP_NUM_BPV; v++) begin
        for (int j = 0; j < 2; j++) begin
          bpv[c][v][0][j] = cFlat[c][v-32+j];
          bpv[c][v][1][j] = cFlat[c][v+1+j];
        end
      end
    end
  end

  // Per-subblock pick, 2x1 rows select independently
  always_comb begin : pickBlk
    bpPkg::sel_t pick;
    for (int c = 0; c < `BP_NUM_COMP; c++) begin
      for (int r = 0; r < `BP_ROWS; r++) begin
        for (int b = 0; b < `BP_NUM_SUB; b++) begin
          pick = bpvTable[b] ? sel2x2[b] : sel2x1[b][r];
          for (int j = 0; j < 2; j++) begin
            predNext[c][r][2*b+j] = bpv[c][pick][r][j];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (parsed) begin
      predOut.pred  <= predNext;
      predOut.quant <= quant;
      predOut.qp    <= qp;
      predOut.mode  <= blockMode;
    end
  end

endmodule

// File: verilog/dequantRecon.sv
// Dequant and reconstruction for BP and BP-skip; other modes leave the output block untouched
`timescale 1ns/1ps
`include "bp_defs.svh"

module dequantRecon (
  input  logic                                                          clk,
  input  logic                                                          stage1Valid,
  input  logic                                                          stage2Valid,
  input  logic [`BP_NUM_COMP-1:0][`BP_PIX_W-1:0]                        minPoint,
  input  logic [12:0]                                                   maxPoint,
  bpPredIf.dst                                                          predIn,
  output bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  reconBlk
);

  localparam logic [7:0] InvScale [8] = '{8'd128, 8'd140, 8'd152, 8'd164,
                                          8'd180, 8'd196, 8'd216, 8'd236};

  logic signed [31:0] resid [`BP_NUM_COMP][`BP_ROWS][`BP_COLS];
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] pred2;
  bpPkg::blockMode_e mode2;

  // Rounded magnitude shift for shift > 0, plain left shift otherwise
  function automatic logic signed [31:0] dequant(input bpPkg::quant_t q, input bpPkg::qp_t qpv);
    logic [7:0] scale;
    int shift;
    logic signed [31:0] absQ;
    logic signed [31:0] mag;
    scale = InvScale[qpv[2:0]];
    shift = 9 - int'(qpv[`BP_QP_W-1:3]);
    if (shift > 0) begin
      absQ = (q < 0) ? -32'(q) : 32'(q);
      mag = (absQ * 32'(scale) + (32'sd1 <<< (shift - 1))) >>> shift;
      return (q < 0) ? -mag : mag;
    end
    return (32'(q) * $signed({24'd0, scale})) <<< (-shift);
  endfunction

  function automatic bpPkg::pixel_t clipRecon(input bpPkg::pixel_t p,
                                              input logic signed [31:0] r,
                                              input logic [`BP_PIX_W-1:0] lo,
                                              input logic [12:0] hi);
    logic signed [33:0] sum;
    logic signed [33:0] loS;
    logic signed [33:0] hiS;
    sum = $signed({20'd0, p}) + 34'(r);
    loS = 34'($signed(lo));
    hiS = $signed({21'd0, hi});
    if (sum < loS) begin
      return loS[`BP_PIX_W-1:0];
    end else if (sum > hiS) begin
      return hiS[`BP_PIX_W-1:0];
    end
    return sum[`BP_PIX_W-1:0];
  endfunction

  // ************************************************************************
  // Stage 2, residual and prediction
  // ************************************************************************
  always_ff @(posedge clk) begin
    if (stage1Valid) begin
      pred2 <= predIn.pred;
      mode2 <= predIn.mode;
      for (int c = 0; c < `BP_NUM_COMP; c++) begin
        for (int r = 0; r < `BP_ROWS; r++) begin
          for (int x = 0; x < `BP_COLS; x++) begin
            resid[c][r][x] <= dequant(predIn.quant[c][r][x], predIn.qp[c]);
          end
        end
      end
    end
  end

  // Output block, written only for BP and BP-skip
  always_ff @(posedge clk) begin
    if (stage2Valid) begin
      for (int c = 0; c < `BP_NUM_COMP; c++) begin
        for (int r = 0; r < `BP_ROWS; r++) begin
          for (int x = 0; x < `BP_COLS; x++) begin
            if (mode2 == bpPkg::MODE_BP) begin
              reconBlk[c][r][x] <= clipRecon(pred2[c][r][x], resid[c][r][x],
                                             minPoint[c], maxPoint);
            end else if (mode2 == bpPkg::MODE_BP_SKIP) begin
              reconBlk[c][r][x] <= pred2[c][r][x]; // Prediction copied as is
            end
          end
        end
      end
    end
  end

endmodule

// File: verilog/leftHistory.sv
// Left-block history for search range C; contents are undefined until the slice FSM says otherwise
`timescale 1ns/1ps
`include "bp_defs.svh"

module leftHistory (
  input  logic                                                          clk,
  input  logic                                                          leftValid,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0]  leftBlk,
  input  bpPkg::sliceState_e                                            state,
  input  bpPkg::pixel_t [`BP_NUM_COMP-1:0]                              meanValue,
  output bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_RANGE_C_LEN-1:0] rangeC
);

  // Index 0 oldest, top index newest
  bpPkg::pixel_t [`BP_LEFT_BLKS-1:0][`BP_NUM_COMP-1:0][`BP_ROWS-1:0][`BP_COLS-1:0] hist;
  bpPkg::pixel_t [`BP_NUM_COMP-1:0][`BP_ROWS-1:0] edgePix; // Column just left of oldest block

  always_ff @(posedge clk) begin
    if (leftValid) begin
      hist <= {leftBlk, hist[`BP_LEFT_BLKS-1:1]};
      for (int c = 0; c < `BP_NUM_COMP; c++) begin
        for (int r = 0; r < `BP_ROWS; r++) begin
          edgePix[c][r] <= hist[0][c][r][`BP_COLS-1];
        end
      end
    end
  end

  // ************************************************************************
  // Mean substitution while the slice has too few left blocks
  // ************************************************************************
  always_comb begin
    for (int c = 0; c < `BP_NUM_COMP; c++) begin
      for (int r = 0; r < `BP_ROWS; r++) begin
        rangeC[c][r][0] = (state == bpPkg::RUN) ? edgePix[c][r] : meanValue[c];
        for (int k = 0; k < `BP_LEFT_BLKS; k++) begin
          for (int j = 0; j < `BP_COLS; j++) begin
            // Newest block needs BLK1, oldest needs BLK4
            rangeC[c][r][1 + k*`BP_COLS + j] = (int'(state) >= int'(bpPkg::BLK4) - k) ?
                                                hist[k][c][r][j] : meanValue[c];
          end
        end
      end
    end
  end

endmodule

// File: verilog/sliceContext.sv
// Slice-start tracking and BP master QP; csc value 1 is taken as YCoCg, maxQp above 127 wraps
`timescale 1ns/1ps
`include "bp_defs.svh"

module sliceContext (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     flush,
  input  logic                                     sos,
  input  logic                                     leftValid,
  input  logic                                     fbls,
  input  logic                                     qpValid,
  input  logic [1:0]                               csc,
  input  logic [12:0]                              midPoint,
  input  logic signed [7:0]                        masterQp,
  input  logic signed [6:0]                        minQp,
  input  logic [8:0]                               maxQp,
  output logic signed [7:0]                        masterQpForBp,
  output bpPkg::sliceState_e                       state,
  output logic                                     firstLine,
  output bpPkg::pixel_t [`BP_NUM_COMP-1:0]         meanValue
);

  logic signed [9:0] qpSum;
  logic signed [9:0] qpClamped;

  // Advances once per left block until four are held
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= bpPkg::IDLE;
    end else if (flush) begin
      state <= bpPkg::IDLE;
    end else begin
      case (state)
        bpPkg::IDLE: if (sos) state <= bpPkg::SOS;
        bpPkg::RUN:  if (sos) state <= bpPkg::SOS;  // Next slice
        default:     if (leftValid) state <= bpPkg::sliceState_e'(state + 3'd1);
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      firstLine <= 1'b1;
    end else if (flush) begin
      firstLine <= 1'b1;
    end else if (qpValid) begin
      firstLine <= fbls;
    end
  end

  always_comb begin
    for (int c = 0; c < `BP_NUM_COMP; c++) begin
      meanValue[c] = (csc == 2'd1 && c > 0) ? '0 : {1'b0, midPoint}; // Chroma centred on zero
    end
  end

  // Offset then clamp into minQp..maxQp
  always_comb begin
    qpSum = 10'(masterQp) + (firstLine ? 10'sd4 : 10'sd2);
    if (qpSum < 10'(minQp)) begin
      qpClamped = 10'(minQp);
    end else if (qpSum > $signed({1'b0, maxQp})) begin
      qpClamped = $signed({1'b0, maxQp});
    end else begin
      qpClamped = qpSum;
    end
  end

  assign masterQpForBp = qpClamped[7:0];

endmodule
